/* compile.f */
+incdir+.
vec_pkg.sv
vreg_bank.sv
vop_decode.sv
vop_execute.sv
vop_result.sv
vec_unit_top.sv
tb_vec_unit.sv

/* tb_vec_unit.sv */
`timescale 1ns/1ps

`include "vec_defs.svh"

module tb_vec_unit import vec_pkg::*; ();

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 4;
	localparam int N_RANDOM = 400;
	localparam int N_CMDS = `VREG_COUNT + N_RANDOM;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 2 * N_CMDS + 20;

	typedef struct packed {
		vaddr_t addr;
		vline_t line;
		logic zero;
		logic [31:0] due;  // Cycle count at which the result must show.
	} expect_t;

	logic iCLOCK;
	logic rst_n;
	logic cmd_valid;
	vcmd_t cmd;
	logic res_valid;
	vaddr_t res_addr;
	vline_t res_data;
	logic res_zero;

	vline_t model [0:`VREG_COUNT-1];
	expect_t exp_q [$];
	logic [31:0] lcg_state = 32'hc432;
	logic [31:0] cycle = 0;
	int err_count = 0;
	int checked = 0;
	int issued = 0;
	vaddr_t prev_rd = '0;
	vaddr_t prev2_rd = '0;

	vec_unit_top u_dut (
		.iCLOCK    (iCLOCK),
		.rst_n     (rst_n),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.res_valid (res_valid),
		.res_addr  (res_addr),
		.res_data  (res_data),
		.res_zero  (res_zero)
	);

	initial begin
		iCLOCK = 1'b0;
		forever #(CLK_PERIOD / 2) iCLOCK = ~iCLOCK;
	end

	always @(posedge iCLOCK) cycle <= cycle + 1;

	// ----------------------------------------------------------------------
	// Random numbers and reference model
	// ----------------------------------------------------------------------
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic vline_t rand_line();
		vline_t v;
		for (int i = 0; i < 16; i++) begin
			v[i*32 +: 32] = lcg_next();
		end
		return v;
	endfunction

	function automatic vmask_t rand_mask();
		vmask_t m;
		m[31:0] = lcg_next();
		m[63:32] = lcg_next();
		return m;
	endfunction

	// Lane rule on integers, modulo 256.
	function automatic vline_t lane_rule(input vop_e op, input vline_t a, input vline_t b,
		input vline_t imm);
		vline_t r;
		int x;
		int y;
		for (int i = 0; i < `VEC_BYTES; i++) begin
			x = a[i*8 +: 8];
			y = b[i*8 +: 8];
			case (op)
				VOP_LOAD: r[i*8 +: 8] = imm[i*8 +: 8];
				VOP_ADD:  r[i*8 +: 8] = 8'((x + y) % 256);
				VOP_SUB:  r[i*8 +: 8] = 8'((x - y + 256) % 256);
				VOP_AND:  r[i*8 +: 8] = 8'(x & y);
				VOP_OR:   r[i*8 +: 8] = 8'(x | y);
				VOP_XOR:  r[i*8 +: 8] = 8'(x ^ y);
				VOP_MINU: r[i*8 +: 8] = 8'((x < y) ? x : y);
				default:  r[i*8 +: 8] = 8'(x);
			endcase
		end
		return r;
	endfunction

	function automatic vline_t merge_line(input vmask_t mask, input vline_t nl, input vline_t ol);
		vline_t m;
		for (int i = 0; i < `VEC_BYTES; i++) begin
			m[i*8 +: 8] = mask[i] ? nl[i*8 +: 8] : ol[i*8 +: 8];
		end
		return m;
	endfunction

	// ----------------------------------------------------------------------
	// Drivers
	// ----------------------------------------------------------------------
	task automatic send_cmd(input vcmd_t c);
		vline_t res;
		expect_t e;
		@(posedge iCLOCK);
		cmd_valid <= 1'b1;
		cmd <= c;
		res = lane_rule(c.op, model[c.rd], model[c.rs], c.imm);
		e.addr = c.rd;
		e.line = merge_line(c.mask, res, model[c.rd]);
		e.zero = (e.line == '0);
		e.due = cycle + 3;  // Sampled next edge, shown after the one after.
		model[c.rd] = e.line;
		exp_q.push_back(e);
		prev2_rd = prev_rd;
		prev_rd = c.rd;
		issued++;
	endtask

	task automatic idle_cycle();
		@(posedge iCLOCK);
		cmd_valid <= 1'b0;
	endtask

	initial begin
		vcmd_t c;
		int sel;
		rst_n = 1'b0;
		cmd_valid = 1'b0;
		cmd = '0;
		for (int r = 0; r < `VREG_COUNT; r++) begin
			model[r] = '0;
		end
		repeat (RESET_CYCLES) @(posedge iCLOCK);
		rst_n <= 1'b1;

		// Load every register with a full mask.
		for (int r = 0; r < `VREG_COUNT; r++) begin
			c.op = VOP_LOAD;
			c.rd = vaddr_t'(r);
			c.rs = '0;
			c.mask = '1;
			c.imm = rand_line();
			send_cmd(c);
		end

		while (issued < N_CMDS) begin
			if (((lcg_next() >> 16) & 32'd3) == 0) begin
				idle_cycle();
			end else begin
				c.op = vop_e'((lcg_next() >> 16) % 7);
				c.rd = vaddr_t'(lcg_next() >> 28);
				c.rs = vaddr_t'(lcg_next() >> 28);
				c.mask = rand_mask();
				c.imm = rand_line();
				sel = (lcg_next() >> 16) % 16;
				if (sel == 0) begin
					c.op = VOP_XOR;  // Self xor gives zero.
					c.rs = c.rd;
					c.mask = '1;
				end else if (sel == 1) begin
					c.op = VOP_LOAD;
					c.imm = '0;
					c.mask = '1;
				end else if (sel < 5) begin
					c.rs = prev_rd;
				end else if (sel < 7) begin
					c.rd = prev_rd;
				end else if (sel == 7) begin
					c.rs = prev2_rd;
				end
				send_cmd(c);
			end
		end
		idle_cycle();
		repeat (4) @(posedge iCLOCK);

		if (exp_q.size() != 0) begin
			$display("Run ended with %0d expected results that never appeared", exp_q.size());
			err_count++;
		end
		$display("Results checked: %0d, errors: %0d", checked, err_count);
		if (err_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// ----------------------------------------------------------------------
	// Result checker, sampled mid-cycle
	// ----------------------------------------------------------------------
	always @(negedge iCLOCK) begin
		expect_t e;
		if (res_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				$display("A result for r%0d appeared at %0t with no command outstanding",
					res_addr, $time);
				err_count++;
			end else begin
				e = exp_q.pop_front();
				checked++;
				if (cycle != e.due) begin
					$display("ERROR @%0t: result for r%0d at cycle %0d, expected cycle %0d",
						$time, e.addr, cycle, e.due);
					err_count++;
				end
				if (res_addr !== e.addr) begin
					$display("ERROR @%0t: res_addr %0d, expected %0d", $time, res_addr, e.addr);
					err_count++;
				end
				if (res_data !== e.line) begin
					$display("ERROR @%0t: res_data for r%0d is %h, expected %h",
						$time, e.addr, res_data, e.line);
					err_count++;
				end
				if (res_zero !== e.zero) begin
					$display("ERROR @%0t: res_zero for r%0d is %b, expected %b",
						$time, e.addr, res_zero, e.zero);
					err_count++;
				end
			end
		end else if (res_valid !== 1'b0) begin
			$display("res_valid is unknown at %0t", $time);
			err_count++;
		end else if (exp_q.size() != 0 && exp_q[0].due <= cycle) begin
			e = exp_q.pop_front();
			$display("The result for r%0d due at cycle %0d never appeared", e.addr, e.due);
			err_count++;
		end
	end

	// Watchdog.
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* vec_unit_top.sv */
`timescale 1ns/1ps

module vec_unit_top import vec_pkg::*; (
	input logic iCLOCK,
	input logic rst_n,
	input logic cmd_valid,
	input vcmd_t cmd,
	output logic res_valid,
	output vaddr_t res_addr,
	output vline_t res_data,
	output logic res_zero
);

	vaddr_t rd_addr_a;
	vaddr_t rd_addr_b;
	vdec_t dec;
	vline_t line_a;
	vline_t line_b;
	vexe_t exe;
	vwb_t wb;

	// Shared write side.
	logic wr_ena;
	vaddr_t wr_addr;
	vline_t wr_data;
	vmask_t byte_ena;

	vop_decode u_decode (
		.iCLOCK    (iCLOCK),
		.rst_n     (rst_n),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.dec       (dec)
	);

	// ----------------------------------------------------------------------
	// Two bank copies, one per operand
	// ----------------------------------------------------------------------
	vreg_bank u_bank_a (
		.iCLOCK   (iCLOCK),
		.byte_ena (byte_ena),
		.wr_ena   (wr_ena),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.rd_addr  (rd_addr_a),
		.rd_data  (line_a)
	);

	vreg_bank u_bank_b (
		.iCLOCK   (iCLOCK),
		.byte_ena (byte_ena),
		.wr_ena   (wr_ena),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.rd_addr  (rd_addr_b),
		.rd_data  (line_b)
	);

	vop_execute u_execute (
		.iCLOCK    (iCLOCK),
		.rst_n     (rst_n),
		.dec       (dec),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.line_a    (line_a),
		.line_b    (line_b),
		.wb        (wb),
		.exe       (exe)
	);

	vop_result u_result (
		.exe       (exe),
		.wr_ena    (wr_ena),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.byte_ena  (byte_ena),
		.wb        (wb),
		.res_valid (res_valid),
		.res_addr  (res_addr),
		.res_data  (res_data),
		.res_zero  (res_zero)
	);

endmodule

/* vop_result.sv */
`timescale 1ns/1ps

`include "vec_defs.svh"

module vop_result import vec_pkg::*; (
	input vexe_t exe,
	output logic wr_ena,
	output vaddr_t wr_addr,
	output vline_t wr_data,
	output vmask_t byte_ena,
	output vwb_t wb,
	output logic res_valid,
	output vaddr_t res_addr,
	output vline_t res_data,
	output logic res_zero
);

	vline_t merged;

	// New bytes under the mask, old bytes elsewhere.
	always_comb begin
		for (int i = 0; i < `VEC_BYTES; i++) begin
			merged[i*8 +: 8] = exe.mask[i] ? exe.result[i*8 +: 8] : exe.old[i*8 +: 8];
		end
	end

	// ----------------------------------------------------------------------
	// Bank write, shared by both copies
	// ----------------------------------------------------------------------
	assign wr_ena = exe.valid;
	assign wr_addr = exe.rd;
	assign wr_data = exe.result;  // Bank merges by byte_ena.
	assign byte_ena = exe.mask;

	// Forward source for execute.
	assign wb.valid = exe.valid;
	assign wb.rd = exe.rd;
	assign wb.line = merged;

	// Result outputs.
	assign res_valid = exe.valid;
	assign res_addr = exe.rd;
	assign res_data = merged;
	assign res_zero = (merged == '0);

endmodule

/* vop_execute.sv */
`timescale 1ns/1ps

`include "vec_defs.svh"

module vop_execute import vec_pkg::*; (
	input logic iCLOCK,
	input logic rst_n,
	input vdec_t dec,
	input vaddr_t rd_addr_a,
	input vaddr_t rd_addr_b,
	input vline_t line_a,
	input vline_t line_b,
	input vwb_t wb,
	output vexe_t exe
);

	vline_t src_a;
	vline_t src_b;
	vline_t lane_out;
	logic fwd_a;
	logic fwd_b;

	// One lane, wrapping 8-bit arithmetic.
	function automatic logic [7:0] lane_op(
		input vop_e op,
		input logic [7:0] a,
		input logic [7:0] b,
		input logic [7:0] imm
	);
		logic [7:0] r;
		case (op)
			VOP_LOAD: r = imm;
			VOP_ADD:  r = a + b;
			VOP_SUB:  r = a - b;
			VOP_AND:  r = a & b;
			VOP_OR:   r = a | b;
			VOP_XOR:  r = a ^ b;
			VOP_MINU: r = (a < b) ? a : b;
			default:  r = a;
		endcase
		return r;
	endfunction

	// ----------------------------------------------------------------------
	// Forwarding from the result stage
	// ----------------------------------------------------------------------
	assign fwd_a = wb.valid && (wb.rd == rd_addr_a);
	assign fwd_b = wb.valid && (wb.rd == rd_addr_b);
	assign src_a = fwd_a ? wb.line : line_a;
	assign src_b = fwd_b ? wb.line : line_b;

	always_comb begin
		for (int i = 0; i < `VEC_BYTES; i++) begin
			lane_out[i*8 +: 8] = lane_op(dec.op, src_a[i*8 +: 8], src_b[i*8 +: 8],
				dec.imm[i*8 +: 8]);
		end
	end

	// ----------------------------------------------------------------------
	// Execute register
	// ----------------------------------------------------------------------
	always_ff @(posedge iCLOCK) begin
		if (!rst_n) begin
			exe.valid <= 1'b0;
		end else begin
			exe.valid <= dec.valid;
		end
	end

	always_ff @(posedge iCLOCK) begin
		exe.rd <= dec.rd;
		exe.mask <= dec.mask;
		exe.result <= lane_out;
		exe.old <= src_a;  // Needed for the merge.
	end

endmodule

/* vop_decode.sv */
`timescale 1ns/1ps

module vop_decode import vec_pkg::*; (
	input logic iCLOCK,
	input logic rst_n,
	input logic cmd_valid,
	input vcmd_t cmd,
	output vaddr_t rd_addr_a,
	output vaddr_t rd_addr_b,
	output vdec_t dec
);

	// ----------------------------------------------------------------------
	// Stage valid
	// ----------------------------------------------------------------------
	always_ff @(posedge iCLOCK) begin
		if (!rst_n) begin
			dec.valid <= 1'b0;
		end else begin
			dec.valid <= cmd_valid;
		end
	end

	// Payload, held while idle.
	always_ff @(posedge iCLOCK) begin
		if (cmd_valid) begin
			dec.op <= cmd.op;
			dec.rd <= cmd.rd;
			dec.mask <= cmd.mask;
			rd_addr_a <= cmd.rd;
			rd_addr_b <= cmd.rs;  // Ignored for loads.
			if (cmd.op == VOP_LOAD) begin
				dec.imm <= cmd.imm;
			end else begin
				dec.imm <= '0;  // Keep the wide bus quiet.
			end
		end
	end

endmodule

/* vreg_bank.sv */
`timescale 1ns/1ps

`include "vec_defs.svh"

module vreg_bank import vec_pkg::*; (
	input logic iCLOCK,
	input vmask_t byte_ena,
	input logic wr_ena,
	input vaddr_t wr_addr,
	input vline_t wr_data,
	input vaddr_t rd_addr,
	output vline_t rd_data
);

	vline_t mem [0:`VREG_COUNT-1];

	// ----------------------------------------------------------------------
	// Byte-enabled write
	// ----------------------------------------------------------------------
	always_ff @(posedge iCLOCK) begin
		if (wr_ena) begin
			for (int i = 0; i < `VEC_BYTES; i++) begin
				if (byte_ena[i]) begin
					mem[wr_addr][i*8 +: 8] <= wr_data[i*8 +: 8];
				end
			end
		end
	end

	// Asynchronous read.
	assign rd_data = mem[rd_addr];

endmodule

/* vec_pkg.sv */
`include "vec_defs.svh"

package vec_pkg;

	typedef logic [`VEC_BITS-1:0] vline_t;
	typedef logic [`VEC_BYTES-1:0] vmask_t;  // One bit per byte lane.
	typedef logic [`VREG_AW-1:0] vaddr_t;

	typedef enum logic [2:0] {
		VOP_LOAD = 3'd0,
		VOP_ADD  = 3'd1,
		VOP_SUB  = 3'd2,
		VOP_AND  = 3'd3,
		VOP_OR   = 3'd4,
		VOP_XOR  = 3'd5,
		VOP_MINU = 3'd6
	} vop_e;

	// ----------------------------------------------------------------------
	// Stage records
	// ----------------------------------------------------------------------
	typedef struct packed {
		vop_e op;
		vaddr_t rd;  // Destination and first source.
		vaddr_t rs;
		vmask_t mask;
		vline_t imm;
	} vcmd_t;

	typedef struct packed {
		logic valid;
		vop_e op;
		vaddr_t rd;
		vmask_t mask;
		vline_t imm;
	} vdec_t;

	typedef struct packed {
		logic valid;
		vaddr_t rd;
		vmask_t mask;
		vline_t result;
		vline_t old;  // Prior rd value, after forwarding.
	} vexe_t;

	typedef struct packed {
		logic valid;
		vaddr_t rd;
		vline_t line;  // Merged line.
	} vwb_t;

endpackage

/* vec_defs.svh */
`ifndef VEC_DEFS_SVH
`define VEC_DEFS_SVH

// Lane geometry.
`define VEC_BYTES 64
`define VEC_BITS 512

// Register bank.
`define VREG_COUNT 16
`define VREG_AW 4

`endif
